// File: rtl/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    localparam int pc_w  = 32;    // address and data word
    localparam int reg_w = 5;     // gpr number

    // instruction class as seen by the memory stages
    typedef enum logic [2:0] {
        op_alu   = 3'd0,
        op_load  = 3'd1,
        op_store = 3'd2,
        op_mfc0  = 3'd3,
        op_mtc0  = 3'd4,
        op_eret  = 3'd5
    } op_t;

    typedef enum logic [1:0] {
        sz_byte = 2'd0,
        sz_half = 2'd1,
        sz_word = 2'd2
    } size_t;

    // only the top three bits take part in the segment decode
    localparam logic [pc_w-1:0] seg_kseg0_base = 32'h8000_0000;   // unmapped, k0 cache attr
    localparam logic [pc_w-1:0] seg_kseg1_base = 32'hA000_0000;   // unmapped, uncached

endpackage

`default_nettype wire

// File: rtl/cp0_pkg.sv
`default_nettype none

package cp0_pkg;

    localparam logic [4:0] cp0_badvaddr = 5'd8;
    localparam logic [4:0] cp0_status   = 5'd12;
    localparam logic [4:0] cp0_cause    = 5'd13;
    localparam logic [4:0] cp0_epc      = 5'd14;
    localparam logic [4:0] cp0_config   = 5'd16;

    localparam logic [4:0] exc_int  = 5'd0;
    localparam logic [4:0] exc_tlbl = 5'd2;    // refill on load
    localparam logic [4:0] exc_tlbs = 5'd3;    // refill on store
    localparam logic [4:0] exc_adel = 5'd4;
    localparam logic [4:0] exc_ades = 5'd5;
    localparam logic [4:0] exc_sys  = 5'd8;

    localparam logic [31:0] exc_vector   = 32'hBFC0_0380;   // bev=1 general vector
    localparam logic [31:0] status_reset = 32'h0040_0000;   // bev only

    typedef struct packed {
        logic [15:0] rsvd_hi;
        logic [7:0]  im;
        logic [5:0]  rsvd_lo;
        logic        exl;
        logic        ie;
    } status_view_t;

    typedef struct packed {
        logic        bd;
        logic [14:0] rsvd_hi;
        logic [5:0]  ip_hw;
        logic [1:0]  ip_sw;
        logic        rsvd_mid;
        logic [4:0]  exccode;
        logic [1:0]  rsvd_lo;
    } cause_view_t;

    typedef union packed {
        status_view_t status;
        cause_view_t  cause;
    } cp0_word_u;

endpackage

`default_nettype wire

// File: rtl/cp0_regs.sv
`timescale 1ns/10ps
`default_nettype none

module cp0_regs (
    input  logic               clk,
    input  logic               reset,
    input  logic [5:0]         ext_int,
    input  logic [4:0]         cp0_rd,
    output logic [31:0]        cp0_rdata,
    input  logic               cp0_we,
    input  cp0_pkg::cp0_word_u cp0_wdata,
    input  logic               commit_ex,
    input  logic               commit_eret,
    input  logic [4:0]         commit_exccode,
    input  logic [31:0]        commit_pc,
    input  logic [31:0]        commit_badvaddr,
    output logic               int_pending,
    output logic [31:0]        epc,
    output logic               k0_cached
);
    import cp0_pkg::*;

    logic [31:0] badvaddr;
    cp0_word_u   status_r;
    cp0_word_u   cause_r;
    logic [2:0]  k0;            // config cache attribute for kseg0
    logic        addr_fault;
    logic [7:0]  ip;

    // refill faults report the address as well
    assign addr_fault = commit_exccode == exc_adel || commit_exccode == exc_ades ||
                        commit_exccode == exc_tlbl || commit_exccode == exc_tlbs;

    always_ff @(posedge clk) begin
        if (reset) begin
            status_r <= status_reset;
            cause_r  <= '0;
            k0       <= 3'd3;
        end else begin
            cause_r.cause.ip_hw <= ext_int;      // pins sampled every cycle
            if (commit_ex) begin
                status_r.status.exl   <= 1'b1;
                cause_r.cause.exccode <= commit_exccode;
            end else if (commit_eret) begin
                status_r.status.exl <= 1'b0;
            end else if (cp0_we) begin
                case (cp0_rd)
                    cp0_status: begin
                        status_r.status.im  <= cp0_wdata.status.im;
                        status_r.status.exl <= cp0_wdata.status.exl;
                        status_r.status.ie  <= cp0_wdata.status.ie;
                    end
                    cp0_cause:  cause_r.cause.ip_sw <= cp0_wdata.cause.ip_sw;   // sw irq only
                    cp0_config: k0 <= cp0_wdata[2:0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (commit_ex) begin
            epc <= commit_pc;
            if (addr_fault) begin
                badvaddr <= commit_badvaddr;
            end
        end else if (cp0_we && cp0_rd == cp0_epc) begin
            epc <= cp0_wdata;
        end
    end

    always_comb begin
        case (cp0_rd)
            cp0_badvaddr: cp0_rdata = badvaddr;
            cp0_status:   cp0_rdata = status_r;
            cp0_cause:    cp0_rdata = cause_r;
            cp0_epc:      cp0_rdata = epc;
            cp0_config:   cp0_rdata = {1'b1, 28'd0, k0};   // m bit set, no config1 detail
            default:      cp0_rdata = 32'd0;
        endcase
    end

    assign ip          = {cause_r.cause.ip_hw, cause_r.cause.ip_sw};
    assign int_pending = |(ip & status_r.status.im) && status_r.status.ie &&
                         !status_r.status.exl;
    assign k0_cached   = k0 == 3'd3;

    // one instruction retires per edge, so it cannot be both
    a_commit_excl: assert property (@(posedge clk) disable iff (reset)
        !(commit_ex && commit_eret));

endmodule

`default_nettype wire

// File: rtl/addr_check.sv
`timescale 1ns/10ps
`default_nettype none

module addr_check (
    input  logic            [31:0] vaddr,
    input  pipe_pkg::op_t          op,
    input  pipe_pkg::size_t        size,
    input  logic                   k0_cached,
    output logic            [31:0] paddr,
    output logic                   uncached,
    output logic                   addr_ex,
    output logic            [4:0]  addr_exccode
);
    import pipe_pkg::*;
    import cp0_pkg::*;

    logic is_store;
    logic is_mem;
    logic in_kseg0;
    logic in_kseg1;
    logic unmapped;
    logic misaligned;

    assign is_store = op == op_store;
    assign is_mem   = op == op_load || is_store;
    assign in_kseg0 = vaddr[31:29] == seg_kseg0_base[31:29];
    assign in_kseg1 = vaddr[31:29] == seg_kseg1_base[31:29];
    assign unmapped = in_kseg0 || in_kseg1;

    always_comb begin
        case (size)
            sz_half: misaligned = vaddr[0];
            sz_word: misaligned = |vaddr[1:0];
            default: misaligned = 1'b0;
        endcase
    end

    // mapped space passes through untranslated, it faults anyway
    assign paddr    = unmapped ? {3'b000, vaddr[28:0]} : vaddr;
    assign uncached = in_kseg1 || (in_kseg0 && !k0_cached);

    always_comb begin
        addr_ex      = 1'b0;
        addr_exccode = 5'd0;
        if (is_mem && misaligned) begin             // alignment wins over refill
            addr_ex      = 1'b1;
            addr_exccode = is_store ? exc_ades : exc_adel;
        end else if (is_mem && !unmapped) begin     // no tlb, always a refill
            addr_ex      = 1'b1;
            addr_exccode = is_store ? exc_tlbs : exc_tlbl;
        end
    end

endmodule

`default_nettype wire

// File: rtl/m1_stage.sv
`timescale 1ns/10ps
`default_nettype none

module m1_stage (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              in_valid,
    output logic                              in_allowin,
    input  pipe_pkg::op_t                     in_op,
    input  logic        [pipe_pkg::pc_w-1:0]  in_pc,
    input  logic        [31:0]                in_alu_result,
    input  logic        [31:0]                in_rt_value,
    input  pipe_pkg::size_t                   in_size,
    input  logic        [4:0]                 in_cp0_rd,
    input  logic        [pipe_pkg::reg_w-1:0] in_dest,
    input  logic                              in_gr_we,
    input  logic                              in_ex,
    input  logic        [4:0]                 in_exccode,
    output logic                              out_valid,
    input  logic                              out_allowin,
    output logic        [pipe_pkg::pc_w-1:0]  out_pc,
    output logic        [31:0]                out_result,
    output logic        [pipe_pkg::reg_w-1:0] out_dest,
    output logic                              out_gr_we,
    output logic                              out_ex,
    output logic        [4:0]                 out_exccode,
    output logic                              data_valid,
    output logic                              data_op,
    output logic        [31:0]                data_paddr,
    output logic        [3:0]                 data_wstrb,
    output logic        [31:0]                data_wdata,
    output pipe_pkg::size_t                   data_size,
    output logic                              data_uncached,
    input  logic                              dcache_busy,
    output logic                              flush,
    output logic        [31:0]                flush_pc,
    output logic        [4:0]                 cp0_rd,
    input  logic        [31:0]                cp0_rdata,
    output logic                              cp0_we,
    output cp0_pkg::cp0_word_u                cp0_wdata,
    output logic                              commit_ex,
    output logic                              commit_eret,
    output logic        [4:0]                 commit_exccode,
    output logic        [31:0]                commit_pc,
    output logic        [31:0]                commit_badvaddr,
    input  logic                              int_pending,
    input  logic        [31:0]                epc,
    output logic        [31:0]                vaddr,
    output pipe_pkg::op_t                     op,
    output pipe_pkg::size_t                   size,
    input  logic        [31:0]                paddr,
    input  logic                              uncached,
    input  logic                              addr_ex,
    input  logic        [4:0]                 addr_exccode
);
    import pipe_pkg::*;
    import cp0_pkg::*;

    logic              valid;
    op_t               op_r;
    logic [pc_w-1:0]   pc_r;
    logic [31:0]       alu_r;
    logic [31:0]       rt_r;
    size_t             size_r;
    logic [4:0]        cp0_rd_r;
    logic [reg_w-1:0]  dest_r;
    logic              gr_we_r;
    logic              ex_r;
    logic [4:0]        exccode_r;
    logic              is_mem;
    logic              ex;
    logic              ready_go;
    logic              fire;
    logic [3:0]        store_mask;
    logic [31:0]       store_data;
    logic [4:0]        lane_shift;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (flush) begin
            valid <= 1'b0;                          // younger work is dropped
        end else if (in_allowin) begin
            valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            op_r      <= in_op;
            pc_r      <= in_pc;
            alu_r     <= in_alu_result;
            rt_r      <= in_rt_value;
            size_r    <= in_size;
            cp0_rd_r  <= in_cp0_rd;
            dest_r    <= in_dest;
            gr_we_r   <= in_gr_we;
            ex_r      <= in_ex;
            exccode_r <= in_exccode;
        end
    end

    assign is_mem = op_r == op_load || op_r == op_store;
    assign ex     = ex_r || int_pending || addr_ex;

    // older exception first, then interrupt, then this stage's address fault
    assign out_exccode = ex_r        ? exccode_r :
                         int_pending ? exc_int   : addr_exccode;

    assign ready_go   = !is_mem || ex || !dcache_busy;
    assign out_valid  = valid && ready_go;
    assign fire       = out_valid && out_allowin;
    assign in_allowin = (!valid || (ready_go && out_allowin)) && !flush;

    assign out_pc     = pc_r;
    assign out_dest   = dest_r;
    assign out_gr_we  = gr_we_r;
    assign out_ex     = ex;
    assign out_result = op_r == op_mfc0 ? cp0_rdata : alu_r;

    assign vaddr = alu_r;
    assign op    = op_r;
    assign size  = size_r;

    always_comb begin
        case (size_r)
            sz_byte: begin
                store_mask = 4'b0001 << alu_r[1:0];
                store_data = {24'd0, rt_r[7:0]};
            end
            sz_half: begin
                store_mask = alu_r[1] ? 4'b1100 : 4'b0011;
                store_data = {16'd0, rt_r[15:0]};
            end
            default: begin
                store_mask = 4'b1111;
                store_data = rt_r;
            end
        endcase
    end

    assign lane_shift    = {alu_r[1:0], 3'b000};
    assign data_valid    = fire && is_mem && !ex;
    assign data_op       = op_r == op_store;
    assign data_paddr    = paddr;
    assign data_wstrb    = data_op ? store_mask : 4'b0000;   // loads write nothing
    assign data_wdata    = store_data << lane_shift;
    assign data_size     = size_r;
    assign data_uncached = uncached;

    assign cp0_rd          = cp0_rd_r;
    assign cp0_we          = fire && op_r == op_mtc0 && !ex;
    assign cp0_wdata       = rt_r;
    assign commit_ex       = fire && ex;
    assign commit_eret     = fire && op_r == op_eret && !ex;
    assign commit_exccode  = out_exccode;
    assign commit_pc       = pc_r;
    assign commit_badvaddr = ex_r ? pc_r : alu_r;   // fetch fault reports the pc

    assign flush    = commit_ex || commit_eret;
    assign flush_pc = ex ? exc_vector : epc;

    // a request only leaves for an aligned address in kseg0 or kseg1
    a_req_clean: assert property (@(posedge clk) disable iff (reset)
        data_valid |-> (alu_r[31:30] == 2'b10 && paddr[31:29] == 3'b000 &&
                        !(size_r == sz_half && alu_r[0]) &&
                        !(size_r == sz_word && alu_r[1:0] != 2'b00)));

    // the flushing instruction leaves and nothing follows it in
    a_flush_drain: assert property (@(posedge clk) disable iff (reset)
        flush |-> out_valid ##1 !out_valid);

endmodule

`default_nettype wire

// File: rtl/mem1_top.sv
`timescale 1ns/10ps
`default_nettype none

module mem1_top (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              in_valid,
    output logic                              in_allowin,
    input  pipe_pkg::op_t                     in_op,
    input  logic        [pipe_pkg::pc_w-1:0]  in_pc,
    input  logic        [31:0]                in_alu_result,
    input  logic        [31:0]                in_rt_value,
    input  pipe_pkg::size_t                   in_size,
    input  logic        [4:0]                 in_cp0_rd,
    input  logic        [pipe_pkg::reg_w-1:0] in_dest,
    input  logic                              in_gr_we,
    input  logic                              in_ex,
    input  logic        [4:0]                 in_exccode,
    output logic                              out_valid,
    input  logic                              out_allowin,
    output logic        [pipe_pkg::pc_w-1:0]  out_pc,
    output logic        [31:0]                out_result,
    output logic        [pipe_pkg::reg_w-1:0] out_dest,
    output logic                              out_gr_we,
    output logic                              out_ex,
    output logic        [4:0]                 out_exccode,
    output logic                              data_valid,
    output logic                              data_op,
    output logic        [31:0]                data_paddr,
    output logic        [3:0]                 data_wstrb,
    output logic        [31:0]                data_wdata,
    output pipe_pkg::size_t                   data_size,
    output logic                              data_uncached,
    input  logic                              dcache_busy,
    input  logic        [5:0]                 ext_int,
    output logic                              flush,
    output logic        [31:0]                flush_pc
);
    import pipe_pkg::*;
    import cp0_pkg::*;

    logic [4:0]  cp0_rd;
    logic [31:0] cp0_rdata;
    logic        cp0_we;
    cp0_word_u   cp0_wdata;
    logic        commit_ex;
    logic        commit_eret;
    logic [4:0]  commit_exccode;
    logic [31:0] commit_pc;
    logic [31:0] commit_badvaddr;
    logic        int_pending;
    logic [31:0] epc;
    logic        k0_cached;
    logic [31:0] vaddr;
    op_t         op;
    size_t       size;
    logic [31:0] paddr;
    logic        uncached;
    logic        addr_ex;
    logic [4:0]  addr_exccode;

    // port names line up across the three blocks
    m1_stage u_stage (.*);

    cp0_regs u_cp0 (.*);

    addr_check u_addr (.*);

endmodule

`default_nettype wire

// File: testbench/tb_mem1.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mem1;
    import pipe_pkg::*;
    import cp0_pkg::*;

    localparam int n_instr    = 2000;
    localparam int max_cycles = n_instr * 4;    // random stalls keep throughput near one half

    typedef struct {
        op_t         op;
        logic [31:0] pc;
        logic [31:0] alu;
        logic [31:0] rt;
        size_t       size;
        logic [4:0]  cp0_rd;
        logic [4:0]  dest;
        logic        gr_we;
        logic        ex;
        logic [4:0]  exccode;
    } instr_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        in_valid;
    logic        in_allowin;
    op_t         in_op;
    logic [31:0] in_pc;
    logic [31:0] in_alu_result;
    logic [31:0] in_rt_value;
    size_t       in_size;
    logic [4:0]  in_cp0_rd;
    logic [4:0]  in_dest;
    logic        in_gr_we;
    logic        in_ex;
    logic [4:0]  in_exccode;
    logic        out_valid;
    logic        out_allowin;
    logic [31:0] out_pc;
    logic [31:0] out_result;
    logic [4:0]  out_dest;
    logic        out_gr_we;
    logic        out_ex;
    logic [4:0]  out_exccode;
    logic        data_valid;
    logic        data_op;
    logic [31:0] data_paddr;
    logic [3:0]  data_wstrb;
    logic [31:0] data_wdata;
    size_t       data_size;
    logic        data_uncached;
    logic        dcache_busy;
    logic [5:0]  ext_int;
    logic        flush;
    logic [31:0] flush_pc;

    instr_t      q[$];          // accepted, not yet fired
    instr_t      pend;          // held on the execute side until accepted
    instr_t      h;
    logic        have_pend;
    int          issued;
    int          cycles;
    int          fired;
    int          flushes;
    int          requests;
    int          value_errs;
    int          other_errs;
    logic [31:0] next_pc;

    // reference copy of cp0
    logic [7:0]  m_im;
    logic        m_exl;
    logic        m_ie;
    logic [5:0]  m_ip_hw;
    logic [1:0]  m_ip_sw;
    logic [4:0]  m_exccode;
    logic [31:0] m_epc;
    logic [31:0] m_badvaddr;
    logic [2:0]  m_k0;
    logic        epc_known;     // epc and badvaddr have no reset value
    logic        bva_known;

    logic        intp;
    logic        have;
    logic        ex;
    logic        is_mem;
    logic        exp_valid;
    logic        exp_fire;
    logic        exp_req;
    logic        exp_flush;
    logic        exp_allowin;
    logic [4:0]  code;

    mem1_top dut (.*);

    always #10 clk = ~clk;

    function automatic logic [5:0] fault_code(instr_t i);
        logic mem;
        logic st;
        logic bad_align;
        mem       = i.op == op_load || i.op == op_store;
        st        = i.op == op_store;
        bad_align = (i.size == sz_half && i.alu[0]) ||
                    (i.size == sz_word && i.alu[1:0] != 2'b00);
        if (mem && bad_align) return {1'b1, st ? exc_ades : exc_adel};
        if (mem && i.alu[31:30] != 2'b10) return {1'b1, st ? exc_tlbs : exc_tlbl};
        return 6'd0;
    endfunction

    function automatic logic [31:0] cp0_value(logic [4:0] rd);
        case (rd)
            cp0_badvaddr: return m_badvaddr;
            cp0_status:   return 32'h0040_0000 | {16'd0, m_im, 6'd0, m_exl, m_ie};
            cp0_cause:    return {16'd0, m_ip_hw, m_ip_sw, 1'b0, m_exccode, 2'b00};
            cp0_epc:      return m_epc;
            cp0_config:   return {1'b1, 28'd0, m_k0};
            default:      return 32'd0;
        endcase
    endfunction

    // the bytes the access covers, from its size-aligned base upward
    function automatic logic [3:0] lane_mask(size_t s, logic [1:0] lo);
        int         nbytes;
        int         first;
        logic [3:0] m;
        nbytes = s == sz_byte ? 1 : s == sz_half ? 2 : 4;
        first  = int'(lo) & ~(nbytes - 1);
        for (int k = 0; k < 4; k++) begin
            m[k] = k >= first && k < first + nbytes;
        end
        return m;
    endfunction

    // replicate the datum across the word, then keep the enabled lanes
    function automatic logic [31:0] lane_data(size_t s, logic [1:0] lo, logic [31:0] rt);
        logic [31:0] rep;
        logic [3:0]  m;
        logic [31:0] res;
        rep = s == sz_byte ? {4{rt[7:0]}} : s == sz_half ? {2{rt[15:0]}} : rt;
        m   = lane_mask(s, lo);
        for (int k = 0; k < 4; k++) begin
            res[8*k +: 8] = m[k] ? rep[8*k +: 8] : 8'h00;
        end
        return res;
    endfunction

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        $display("FAIL %s got %h expected %h (cycle %0d)", name, got, exp, cycles);
        value_errs++;
    endtask

    task automatic make_instr(output instr_t i);
        int unsigned r;
        logic [31:0] a;
        r      = $urandom % 100;
        i.op   = r < 25 ? op_alu : r < 50 ? op_load : r < 70 ? op_store :
                 r < 82 ? op_mfc0 : r < 94 ? op_mtc0 : op_eret;
        i.size = size_t'(2'($urandom % 3));
        a      = $urandom;
        r      = $urandom % 10;
        a[31:29] = r < 4 ? seg_kseg0_base[31:29] : r < 8 ? seg_kseg1_base[31:29] :
                   r == 8 ? 3'b000 : 3'b110;
        if ($urandom % 5 != 0) begin                // mostly aligned
            if (i.size == sz_half) a[0] = 1'b0;
            if (i.size == sz_word) a[1:0] = 2'b00;
        end
        i.alu   = a;
        i.pc    = next_pc;
        next_pc = next_pc + 32'd4;
        r        = $urandom % 5;
        i.cp0_rd = r == 0 ? cp0_badvaddr : r == 1 ? cp0_status : r == 2 ? cp0_cause :
                   r == 3 ? cp0_epc : cp0_config;
        i.rt = $urandom;
        if (i.op == op_mtc0 && i.cp0_rd == cp0_status) i.rt[1] = $urandom % 4 == 0;
        if (i.op == op_mtc0 && i.cp0_rd == cp0_config) begin
            i.rt[2:0] = ($urandom % 2 == 0) ? 3'd3 : 3'd2;      // cached or uncached k0
        end
        i.dest    = 5'($urandom);
        i.gr_we   = 1'($urandom);
        i.ex      = $urandom % 40 == 0;
        i.exccode = i.ex ? exc_sys : 5'd0;
    endtask

    task automatic drive_inputs();
        if (!have_pend && issued < n_instr) begin
            make_instr(pend);
            have_pend = 1'b1;
            issued++;
        end
        if (have_pend) begin
            in_op         = pend.op;
            in_pc         = pend.pc;
            in_alu_result = pend.alu;
            in_rt_value   = pend.rt;
            in_size       = pend.size;
            in_cp0_rd     = pend.cp0_rd;
            in_dest       = pend.dest;
            in_gr_we      = pend.gr_we;
            in_ex         = pend.ex;
            in_exccode    = pend.exccode;
        end
        in_valid    = have_pend && ($urandom % 4 != 0);
        out_allowin = $urandom % 5 != 0;
        dcache_busy = $urandom % 4 == 0;
        if ($urandom % 8 == 0) begin                // lines stay up for several cycles
            ext_int = ($urandom % 3 == 0) ? 6'b000001 << ($urandom % 6) : 6'd0;
        end
    endtask

    task automatic step_model();
        logic [5:0] fc;
        logic       known;
        intp = |({m_ip_hw, m_ip_sw} & m_im) && m_ie && !m_exl;
        have = q.size() != 0;
        if (have) h = q[0];
        fc          = fault_code(h);
        ex          = have && (h.ex || intp || fc[5]);
        code        = h.ex ? h.exccode : intp ? exc_int : fc[4:0];
        is_mem      = h.op == op_load || h.op == op_store;
        exp_valid   = have && (!is_mem || ex || !dcache_busy);
        exp_fire    = exp_valid && out_allowin;
        exp_req     = exp_fire && is_mem && !ex;
        exp_flush   = exp_fire && (ex || h.op == op_eret);
        exp_allowin = (!have || (exp_valid && out_allowin)) && !exp_flush;

        if (out_valid !== exp_valid) report_value("out_valid", 32'(out_valid), 32'(exp_valid));
        if (in_allowin !== exp_allowin) begin
            report_value("in_allowin", 32'(in_allowin), 32'(exp_allowin));
        end
        if (data_valid !== exp_req) report_value("data_valid", 32'(data_valid), 32'(exp_req));
        if (flush !== exp_flush) report_value("flush", 32'(flush), 32'(exp_flush));
        if (exp_valid) begin
            if (out_pc !== h.pc) report_value("out_pc", out_pc, h.pc);
            if (out_dest !== h.dest) report_value("out_dest", 32'(out_dest), 32'(h.dest));
            if (out_gr_we !== h.gr_we) report_value("out_gr_we", 32'(out_gr_we), 32'(h.gr_we));
            if (out_ex !== ex) report_value("out_ex", 32'(out_ex), 32'(ex));
            if (ex && out_exccode !== code) begin
                report_value("out_exccode", 32'(out_exccode), 32'(code));
            end
            known = !(h.cp0_rd == cp0_epc && !epc_known) &&
                    !(h.cp0_rd == cp0_badvaddr && !bva_known);
            if (h.op == op_mfc0 && known && out_result !== cp0_value(h.cp0_rd)) begin
                report_value("out_result", out_result, cp0_value(h.cp0_rd));
            end
            if (h.op != op_mfc0 && out_result !== h.alu) begin
                report_value("out_result", out_result, h.alu);
            end
        end
        if (exp_req) begin
            requests++;
            if (data_op !== (h.op == op_store)) begin
                report_value("data_op", 32'(data_op), 32'(h.op == op_store));
            end
            if (data_paddr !== {3'b000, h.alu[28:0]}) begin
                report_value("data_paddr", data_paddr, {3'b000, h.alu[28:0]});
            end
            if (data_uncached !== (h.alu[29] || m_k0 != 3'd3)) begin    // bit 29 marks kseg1
                report_value("data_uncached", 32'(data_uncached),
                             32'(h.alu[29] || m_k0 != 3'd3));
            end
            if (data_wstrb !== (h.op == op_store ? lane_mask(h.size, h.alu[1:0]) : 4'b0000)) begin
                report_value("data_wstrb", 32'(data_wstrb),
                             32'(h.op == op_store ? lane_mask(h.size, h.alu[1:0]) : 4'b0000));
            end
            if (data_size !== h.size) report_value("data_size", 32'(data_size), 32'(h.size));
            if (h.op == op_store && data_wdata !== lane_data(h.size, h.alu[1:0], h.rt)) begin
                report_value("data_wdata", data_wdata, lane_data(h.size, h.alu[1:0], h.rt));
            end
        end
        if (exp_flush && (ex || epc_known) && flush_pc !== (ex ? exc_vector : m_epc)) begin
            report_value("flush_pc", flush_pc, ex ? exc_vector : m_epc);
        end

        // state as it stands after the coming rising edge
        if (exp_fire) begin
            void'(q.pop_front());
            fired++;
            if (exp_flush) flushes++;
            if (ex) begin
                m_exl     = 1'b1;
                m_exccode = code;
                m_epc     = h.pc;
                epc_known = 1'b1;
                if (code inside {exc_adel, exc_ades, exc_tlbl, exc_tlbs}) begin
                    m_badvaddr = h.ex ? h.pc : h.alu;
                    bva_known  = 1'b1;
                end
            end else if (h.op == op_eret) begin
                m_exl = 1'b0;
            end else if (h.op == op_mtc0) begin
                case (h.cp0_rd)
                    cp0_status: begin
                        m_im  = h.rt[15:8];
                        m_exl = h.rt[1];
                        m_ie  = h.rt[0];
                    end
                    cp0_cause:  m_ip_sw = h.rt[9:8];
                    cp0_epc: begin
                        m_epc     = h.rt;
                        epc_known = 1'b1;
                    end
                    cp0_config: m_k0 = h.rt[2:0];
                    default: ;
                endcase
            end
        end
        m_ip_hw = ext_int;
        if (in_valid && in_allowin) begin
            q.push_back(pend);
            have_pend = 1'b0;
        end
    endtask

    initial begin
        void'($urandom(32'hd16896c2));
        reset         = 1'b1;
        in_valid      = 1'b0;
        in_op         = op_alu;
        in_pc         = 32'd0;
        in_alu_result = 32'd0;
        in_rt_value   = 32'd0;
        in_size       = sz_byte;
        in_cp0_rd     = 5'd0;
        in_dest       = 5'd0;
        in_gr_we      = 1'b0;
        in_ex         = 1'b0;
        in_exccode    = 5'd0;
        out_allowin   = 1'b0;
        dcache_busy   = 1'b0;
        ext_int       = 6'd0;
        have_pend  = 1'b0;
        issued     = 0;
        cycles     = 0;
        fired      = 0;
        flushes    = 0;
        requests   = 0;
        value_errs = 0;
        other_errs = 0;
        next_pc    = 32'hBFC0_0000;
        m_im       = 8'd0;
        m_exl      = 1'b0;
        m_ie       = 1'b0;
        m_ip_hw    = 6'd0;
        m_ip_sw    = 2'd0;
        m_exccode  = 5'd0;
        m_epc      = 32'd0;
        m_badvaddr = 32'd0;
        m_k0       = 3'd3;
        epc_known  = 1'b0;
        bva_known  = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        while (!(issued == n_instr && !have_pend && q.size() == 0) && cycles < max_cycles) begin
            drive_inputs();
            #5;                                     // outputs settled, half a phase before the edge
            step_model();
            cycles++;
            @(negedge clk);
        end
        if (cycles >= max_cycles) begin
            $display("timeout after %0d cycles, %0d of %0d instructions issued, %0d in flight",
                     cycles, issued, n_instr, q.size());
            other_errs++;
        end
        $display("fired %0d, flushes %0d, requests %0d, value errors %0d, other errors %0d",
                 fired, flushes, requests, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
rtl/pipe_pkg.sv
rtl/cp0_pkg.sv
rtl/cp0_regs.sv
rtl/addr_check.sv
rtl/m1_stage.sv
rtl/mem1_top.sv
testbench/tb_mem1.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module tb_mem1 -f src.f -o tb_mem1 \
    && ./obj_dir/tb_mem1 | tee /dev/stderr | grep -q "=== PASS ===" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
